/* design/mcu_pkg.sv */
package mcu_pkg;

    // bus word, used for both address and data
    localparam int word_width = 16;
    typedef logic [word_width-1:0] word_t;

    // address map
    localparam word_t data_base   = 16'h8000;
    localparam word_t periph_base = 16'hFF00;

    // peripheral register offsets, low address byte
    localparam logic [7:0] reg_gpi          = 8'h00;
    localparam logic [7:0] reg_gpo          = 8'h01;
    localparam logic [7:0] reg_uart_data    = 8'h02;
    localparam logic [7:0] reg_uart_status  = 8'h03;
    localparam logic [7:0] reg_timer_period = 8'h04;
    localparam logic [7:0] reg_timer_count  = 8'h05;
    localparam logic [7:0] reg_irq_flags    = 8'h06;
    localparam logic [7:0] reg_irq_enable   = 8'h07;

    // interrupt flag bit positions
    localparam int irq_timer   = 0;
    localparam int irq_uart_rx = 1;
    localparam int irq_gpi0    = 2;
    localparam int irq_uart_tx = 3;

    // extra reset cycles after rst is released
    localparam int stretch_cycles = 4;

endpackage

/* design/sys_bus_if.sv */
interface sys_bus_if;

    // select for this target, from the address decoder
    logic           sel;
    mcu_pkg::word_t addr;
    mcu_pkg::word_t wdata;
    logic           write_en;
    // registered read data, zero when the target was not read
    mcu_pkg::word_t rdata;

    modport initiator (
        output sel,
        output addr,
        output wdata,
        output write_en,
        input  rdata
    );

    modport target (
        input  sel,
        input  addr,
        input  wdata,
        input  write_en,
        output rdata
    );

endinterface

/* design/reset_stretch.sv */
module reset_stretch (
    input  logic clk,
    input  logic rst,
    output logic sys_rst
);

    localparam int cnt_w = $clog2(mcu_pkg::stretch_cycles + 1);

    logic [cnt_w-1:0] cnt;

    // reload while rst is held, count down once it drops
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= cnt_w'(mcu_pkg::stretch_cycles);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign sys_rst = rst | (cnt != '0);

endmodule

/* design/word_ram.sv */
module word_ram #(
    parameter int depth = 128
) (
    input  logic      clk,
    input  logic      rst,
    sys_bus_if.target bus
);

    localparam int idx_w = $clog2(depth);

    mcu_pkg::word_t   mem [depth];
    logic [idx_w-1:0] idx;

    // address wraps modulo the depth
    assign idx = idx_w'(bus.addr % depth);

    always_ff @(posedge clk) begin
        if (bus.sel && bus.write_en) begin
            mem[idx] <= bus.wdata;
        end
    end

    // read data only for a selected read, zero otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.rdata <= '0;
        end else if (bus.sel && !bus.write_en) begin
            bus.rdata <= mem[idx];
        end else begin
            bus.rdata <= '0;
        end
    end

endmodule

/* design/bus_fabric.sv */
module bus_fabric (
    input  logic            clk,
    input  logic            rst,
    input  mcu_pkg::word_t  addr,
    input  mcu_pkg::word_t  wdata,
    input  logic            write_en,
    output mcu_pkg::word_t  rdata,
    sys_bus_if.initiator    code,
    sys_bus_if.initiator    data,
    sys_bus_if.initiator    periph
);

    logic       sel_code;
    logic       sel_data;
    logic       sel_periph;
    logic [2:0] rd_sel_q;

    // 0x0000-0x7fff code, 0x8000-0xfeff data, 0xff00-0xffff peripherals
    assign sel_code   = (addr < mcu_pkg::data_base);
    assign sel_periph = (addr >= mcu_pkg::periph_base);
    assign sel_data   = !sel_code && !sel_periph;

    assign code.sel   = sel_code;
    assign data.sel   = sel_data;
    assign periph.sel = sel_periph;

    // same request goes to every target
    assign code.addr       = addr;
    assign code.wdata      = wdata;
    assign code.write_en   = write_en;
    assign data.addr       = addr;
    assign data.wdata      = wdata;
    assign data.write_en   = write_en;
    assign periph.addr     = addr;
    assign periph.wdata    = wdata;
    assign periph.write_en = write_en;

    // remember which target was read last cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_sel_q <= '0;
        end else begin
            rd_sel_q <= write_en ? 3'b000 : {sel_periph, sel_data, sel_code};
        end
    end

    assign rdata = (code.rdata   & {mcu_pkg::word_width{rd_sel_q[0]}})
                 | (data.rdata   & {mcu_pkg::word_width{rd_sel_q[1]}})
                 | (periph.rdata & {mcu_pkg::word_width{rd_sel_q[2]}});

endmodule

/* design/interval_timer.sv */
module interval_timer (
    input  logic           clk,
    input  logic           rst,
    input  mcu_pkg::word_t period,
    input  logic           restart,
    output mcu_pkg::word_t count,
    output logic           wrap
);

    logic running;

    // a zero period halts the counter
    assign running = (period != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (restart) begin
            count <= '0;
        end else if (running) begin
            if (count >= period) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // pulse in the cycle the count would pass the period
    assign wrap = running && !restart && (count >= period);

endmodule

/* design/uart_core.sv */
module uart_core #(
    parameter int clk_freq = 1000000,
    parameter int baud     = 62500
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       tx_done,
    output logic [7:0] rx_data,
    output logic       rx_strobe,
    input  logic       rx,
    output logic       tx
);

    localparam int bit_clks = clk_freq / baud;
    localparam int half_clks = bit_clks / 2;
    localparam int cnt_w = $clog2(bit_clks);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_bits_st,
        rx_stop
    } rx_state_t;

    logic [9:0]       tx_shift;
    logic [3:0]       tx_bits;
    logic [cnt_w-1:0] tx_cnt;
    logic             tx_active;

    logic             rx_s1;
    logic             rx_s2;
    rx_state_t        rx_state;
    logic [cnt_w-1:0] rx_cnt;
    logic [2:0]       rx_bits;
    logic [7:0]       rx_shift;

    // transmitter: start, 8 data lsb first, stop
    always_ff @(posedge clk) begin
        tx_done <= 1'b0;
        if (rst) begin
            tx_active <= 1'b0;
            tx_bits   <= '0;
            tx_cnt    <= '0;
        end else if (!tx_active) begin
            if (tx_start) begin
                tx_shift  <= {1'b1, tx_data, 1'b0};
                tx_active <= 1'b1;
                tx_bits   <= '0;
                tx_cnt    <= '0;
            end
        end else if (tx_cnt == cnt_w'(bit_clks - 1)) begin
            tx_cnt   <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (tx_bits == 4'd9) begin
                tx_active <= 1'b0;
                tx_done   <= 1'b1;
            end else begin
                tx_bits <= tx_bits + 1'b1;
            end
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    assign tx      = tx_active ? tx_shift[0] : 1'b1;
    assign tx_busy = tx_active;

    // receiver, rx brought into the clock domain first
    always_ff @(posedge clk) begin
        rx_strobe <= 1'b0;
        if (rst) begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            rx_state <= rx_idle;
            rx_cnt   <= '0;
            rx_bits  <= '0;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            case (rx_state)
                rx_idle: begin
                    rx_cnt <= '0;
                    if (!rx_s2) begin
                        rx_state <= rx_start;
                    end
                end
                rx_start: begin
                    // line back high before mid start bit is a glitch
                    if (rx_s2) begin
                        rx_state <= rx_idle;
                    end else if (rx_cnt == cnt_w'(half_clks - 1)) begin
                        rx_cnt   <= '0;
                        rx_bits  <= '0;
                        rx_state <= rx_bits_st;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                rx_bits_st: begin
                    if (rx_cnt == cnt_w'(bit_clks - 1)) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_s2, rx_shift[7:1]};
                        if (rx_bits == 3'd7) begin
                            rx_state <= rx_stop;
                        end else begin
                            rx_bits <= rx_bits + 1'b1;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: begin
                    // middle of the stop bit, drop the byte on a framing error
                    if (rx_cnt == cnt_w'(bit_clks - 1)) begin
                        rx_strobe <= rx_s2;
                        rx_state  <= rx_idle;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign rx_data = rx_shift;

endmodule

/* design/periph_block.sv */
module periph_block #(
    parameter int clk_freq = 1000000,
    parameter int baud     = 62500
) (
    input  logic           clk,
    input  logic           rst,
    sys_bus_if.target      bus,
    input  mcu_pkg::word_t gpi,
    output mcu_pkg::word_t gpo,
    input  logic           rx,
    output logic           tx,
    output logic [3:0]     irq
);

    logic [7:0]     offset;
    logic           wr;
    logic           rd;
    mcu_pkg::word_t period;
    mcu_pkg::word_t count;
    logic           wrap;
    logic           tx_busy;
    logic           tx_done;
    logic [7:0]     rx_data;
    logic           rx_strobe;
    logic [7:0]     rx_byte;
    logic           rx_valid;
    logic           gpi0_q;
    logic [3:0]     flags;
    logic [3:0]     irq_en;
    logic [3:0]     events;
    logic [3:0]     clr;
    mcu_pkg::word_t rd_val;

    assign offset = bus.addr[7:0];
    assign wr     = bus.sel && bus.write_en;
    assign rd     = bus.sel && !bus.write_en;

    interval_timer timer0 (
        .clk     (clk),
        .rst     (rst),
        .period  (period),
        .restart (wr && (offset == mcu_pkg::reg_timer_period)),
        .count   (count),
        .wrap    (wrap)
    );

    // the core drops a start while busy
    uart_core #(
        .clk_freq (clk_freq),
        .baud     (baud)
    ) uart0 (
        .clk       (clk),
        .rst       (rst),
        .tx_data   (bus.wdata[7:0]),
        .tx_start  (wr && (offset == mcu_pkg::reg_uart_data)),
        .tx_busy   (tx_busy),
        .tx_done   (tx_done),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe),
        .rx        (rx),
        .tx        (tx)
    );

    always_comb begin
        events = '0;
        events[mcu_pkg::irq_timer]   = wrap;
        events[mcu_pkg::irq_uart_rx] = rx_strobe;
        events[mcu_pkg::irq_gpi0]    = gpi[0] && !gpi0_q;
        events[mcu_pkg::irq_uart_tx] = tx_done;
    end

    // write one to clear
    assign clr = (wr && (offset == mcu_pkg::reg_irq_flags)) ? bus.wdata[3:0] : 4'h0;

    always_ff @(posedge clk) begin
        if (rst) begin
            gpo      <= '0;
            period   <= '0;
            irq_en   <= '0;
            flags    <= '0;
            irq      <= '0;
            rx_byte  <= '0;
            rx_valid <= 1'b0;
            gpi0_q   <= 1'b0;
        end else begin
            gpi0_q <= gpi[0];
            flags  <= (flags & ~clr) | events;
            irq    <= flags & irq_en;
            if (wr && (offset == mcu_pkg::reg_gpo)) begin
                gpo <= bus.wdata;
            end
            if (wr && (offset == mcu_pkg::reg_timer_period)) begin
                period <= bus.wdata;
            end
            if (wr && (offset == mcu_pkg::reg_irq_enable)) begin
                irq_en <= bus.wdata[3:0];
            end
            // a new byte wins over the read that clears valid
            if (rx_strobe) begin
                rx_byte  <= rx_data;
                rx_valid <= 1'b1;
            end else if (rd && (offset == mcu_pkg::reg_uart_data)) begin
                rx_valid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (offset)
            mcu_pkg::reg_gpi:          rd_val = gpi;
            mcu_pkg::reg_gpo:          rd_val = gpo;
            mcu_pkg::reg_uart_data:    rd_val = {8'h00, rx_byte};
            mcu_pkg::reg_uart_status:  rd_val = {14'h0000, rx_valid, tx_busy};
            mcu_pkg::reg_timer_period: rd_val = period;
            mcu_pkg::reg_timer_count:  rd_val = count;
            mcu_pkg::reg_irq_flags:    rd_val = {12'h000, flags};
            mcu_pkg::reg_irq_enable:   rd_val = {12'h000, irq_en};
            default:                   rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.rdata <= '0;
        end else begin
            bus.rdata <= rd ? rd_val : '0;
        end
    end

endmodule

/* design/mcu_top.sv */
module mcu_top #(
    parameter int clk_freq   = 1000000,
    parameter int baud       = 62500,
    parameter int code_depth = 128,
    parameter int data_depth = 128
) (
    input  logic           clk,
    input  logic           rst,
    // host side of the system bus
    input  mcu_pkg::word_t addr,
    input  mcu_pkg::word_t wdata,
    input  logic           write_en,
    output mcu_pkg::word_t rdata,
    // peripheral pins
    input  mcu_pkg::word_t gpi,
    output mcu_pkg::word_t gpo,
    input  logic           rx,
    output logic           tx,
    output logic [3:0]     irq
);

    logic sys_rst;

    sys_bus_if code_bus ();
    sys_bus_if data_bus ();
    sys_bus_if periph_bus ();

    reset_stretch rst_stretch0 (
        .clk     (clk),
        .rst     (rst),
        .sys_rst (sys_rst)
    );

    bus_fabric fabric0 (
        .clk      (clk),
        .rst      (sys_rst),
        .addr     (addr),
        .wdata    (wdata),
        .write_en (write_en),
        .rdata    (rdata),
        .code     (code_bus.initiator),
        .data     (data_bus.initiator),
        .periph   (periph_bus.initiator)
    );

    word_ram #(.depth(code_depth)) code_ram (
        .clk (clk),
        .rst (sys_rst),
        .bus (code_bus.target)
    );

    word_ram #(.depth(data_depth)) data_ram (
        .clk (clk),
        .rst (sys_rst),
        .bus (data_bus.target)
    );

    periph_block #(
        .clk_freq (clk_freq),
        .baud     (baud)
    ) periph0 (
        .clk (clk),
        .rst (sys_rst),
        .bus (periph_bus.target),
        .gpi (gpi),
        .gpo (gpo),
        .rx  (rx),
        .tx  (tx),
        .irq (irq)
    );

endmodule

/* tb/clock_gen.sv */
module clock_gen #(
    parameter int period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;

endmodule

/* tb/mcu_chk.sv */
module mcu_chk (
    input logic           clk,
    input logic           rst,
    input mcu_pkg::word_t addr,
    input mcu_pkg::word_t wdata,
    input logic           write_en,
    input mcu_pkg::word_t rdata,
    input mcu_pkg::word_t gpo,
    input logic           tx,
    input logic [3:0]     irq
);

    localparam int bit_clks = 16;
    localparam mcu_pkg::word_t irq_enable_addr =
        mcu_pkg::periph_base + mcu_pkg::word_t'(mcu_pkg::reg_irq_enable);

    int         fail_count = 0;
    logic       tx_q;
    logic [7:0] frame_left;
    logic       outputs_idle;

    assign outputs_idle = (tx === 1'b1) && (irq === 4'h0) && (gpo === '0);

    // cycles left in the current tx frame, counted from its start bit
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_q       <= 1'b1;
            frame_left <= '0;
        end else begin
            tx_q <= tx;
            if (frame_left != '0) begin
                frame_left <= frame_left - 1'b1;
            end else if (tx_q && !tx) begin
                frame_left <= 8'(10 * bit_clks - 1);
            end
        end
    end

    a_reset_outputs: assert property (@(posedge clk) rst |=> outputs_idle)
        else begin
            $error("outputs not idle while rst is high");
            fail_count++;
        end

    a_stretch_outputs: assert property (
        @(posedge clk) $fell(rst) |-> outputs_idle [*mcu_pkg::stretch_cycles + 1])
        else begin
            $error("outputs not idle in the reset stretch");
            fail_count++;
        end

    a_write_rdata: assert property (@(posedge clk) write_en |=> (rdata == '0))
        else begin
            $error("rdata not zero after a write cycle");
            fail_count++;
        end

    // start bit holds for a full bit time
    a_start_bit: assert property (
        @(posedge clk) (tx_q && !tx && frame_left == '0) |-> !tx [*bit_clks])
        else begin
            $error("tx start bit shorter than a bit time");
            fail_count++;
        end

    // irq is registered from flags and enable, so it clears two edges after the write
    a_irq_disable: assert property (
        @(posedge clk) (write_en && addr == irq_enable_addr && wdata == '0)
            |-> ##2 (irq == 4'h0))
        else begin
            $error("irq still set after irq_enable was cleared");
            fail_count++;
        end

endmodule

bind mcu_top mcu_chk chk0 (
    .clk      (clk),
    .rst      (rst),
    .addr     (addr),
    .wdata    (wdata),
    .write_en (write_en),
    .rdata    (rdata),
    .gpo      (gpo),
    .tx       (tx),
    .irq      (irq)
);

/* tb/mcu_tb.sv */
module mcu_tb;

    localparam int clk_period      = 20;
    localparam int reset_cycles    = 16;
    localparam int code_depth      = 128;
    localparam int data_depth      = 128;
    localparam int bit_clks        = 16;
    localparam int ram_writes      = 16;
    localparam int ram_cycles      = 2 * ram_writes * 5 + 20;
    localparam int uart_cycles     = 4 * 10 * bit_clks;
    localparam int timer_cycles    = 6 * (40 + 1);
    localparam int watchdog_cycles =
        2 * (reset_cycles + ram_cycles + uart_cycles + timer_cycles);
    // each status poll is two cycles
    localparam int poll_limit      = 10 * bit_clks;

    logic           clk;
    logic           rst;
    mcu_pkg::word_t addr;
    mcu_pkg::word_t wdata;
    logic           write_en;
    mcu_pkg::word_t rdata;
    mcu_pkg::word_t gpi;
    mcu_pkg::word_t gpo;
    wire            serial;
    logic [3:0]     irq;

    int             mismatches = 0;
    int             other_errors = 0;
    logic [31:0]    rng;
    mcu_pkg::word_t code_model [code_depth];
    mcu_pkg::word_t data_model [data_depth];
    mcu_pkg::word_t ram_addr [2 * ram_writes];

    clock_gen #(.period(clk_period)) clk_gen0 (.clk(clk));

    // tx looped back into rx
    mcu_top #(
        .clk_freq   (1000000),
        .baud       (62500),
        .code_depth (code_depth),
        .data_depth (data_depth)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .wdata    (wdata),
        .write_en (write_en),
        .rdata    (rdata),
        .gpi      (gpi),
        .gpo      (gpo),
        .rx       (serial),
        .tx       (serial),
        .irq      (irq)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic mcu_pkg::word_t periph_addr(input logic [7:0] offset);
        return mcu_pkg::periph_base + mcu_pkg::word_t'(offset);
    endfunction

    task automatic bus_write(input mcu_pkg::word_t a, input mcu_pkg::word_t d);
        @(posedge clk);
        addr     <= a;
        wdata    <= d;
        write_en <= 1'b1;
        @(posedge clk);
        write_en <= 1'b0;
    endtask

    // data is sampled mid cycle, one cycle after the address
    task automatic bus_read(input mcu_pkg::word_t a, output mcu_pkg::word_t d);
        @(posedge clk);
        addr     <= a;
        write_en <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        d = rdata;
    endtask

    task automatic check_value(input string name, input mcu_pkg::word_t expected,
                               input mcu_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic read_expect(input mcu_pkg::word_t a, input mcu_pkg::word_t expected);
        mcu_pkg::word_t d;
        bus_read(a, d);
        check_value("rdata", expected, d);
    endtask

    task automatic wait_status(input int bit_idx, input logic level);
        mcu_pkg::word_t d;
        int             polls;
        polls = 0;
        do begin
            bus_read(periph_addr(mcu_pkg::reg_uart_status), d);
            polls++;
        end while (d[bit_idx] !== level && polls < poll_limit);
        if (d[bit_idx] !== level) begin
            $display("error at %0t: uart status bit %0d never became %0b",
                     $time, bit_idx, level);
            other_errors++;
        end
    endtask

    task automatic reset_values();
        read_expect(periph_addr(mcu_pkg::reg_gpo), '0);
        read_expect(periph_addr(mcu_pkg::reg_irq_flags), '0);
        read_expect(periph_addr(mcu_pkg::reg_irq_enable), '0);
    endtask

    task automatic memory_map();
        mcu_pkg::word_t a;
        mcu_pkg::word_t d;
        for (int i = 0; i < 2 * ram_writes; i++) begin
            rng = xorshift32(rng);
            if (i < ram_writes) begin
                a = {1'b0, rng[14:0]};
            end else begin
                a = mcu_pkg::data_base + (rng[15:0] % 16'h7F00);
            end
            rng = xorshift32(rng);
            d = rng[15:0];
            ram_addr[i] = a;
            if (i < ram_writes) begin
                code_model[a % code_depth] = d;
            end else begin
                data_model[a % data_depth] = d;
            end
            bus_write(a, d);
        end
        for (int i = 0; i < 2 * ram_writes; i++) begin
            if (i < ram_writes) begin
                read_expect(ram_addr[i], code_model[ram_addr[i] % code_depth]);
            end else begin
                read_expect(ram_addr[i], data_model[ram_addr[i] % data_depth]);
            end
        end
        // same ram index as 0xff40, but that address belongs to the peripherals
        rng = xorshift32(rng);
        d = rng[15:0];
        data_model[16'h8040 % data_depth] = d;
        bus_write(16'h8040, d);
        bus_write(16'hFF40, ~d);
        read_expect(16'hFF40, '0);
        read_expect(16'h8040, data_model[16'h8040 % data_depth]);
    endtask

    task automatic gpio_edge_irq();
        mcu_pkg::word_t v;
        mcu_pkg::word_t g;
        rng = xorshift32(rng);
        v = rng[15:0];
        bus_write(periph_addr(mcu_pkg::reg_gpo), v);
        @(negedge clk);
        check_value("gpo", v, gpo);
        read_expect(periph_addr(mcu_pkg::reg_gpo), v);
        rng = xorshift32(rng);
        g = rng[15:0] & 16'hFFFE;
        @(posedge clk);
        gpi <= g;
        read_expect(periph_addr(mcu_pkg::reg_gpi), g);
        bus_write(periph_addr(mcu_pkg::reg_irq_flags), 16'h000F);
        read_expect(periph_addr(mcu_pkg::reg_irq_flags), '0);
        bus_write(periph_addr(mcu_pkg::reg_irq_enable), 16'h1 << mcu_pkg::irq_gpi0);
        @(posedge clk);
        gpi <= g | 16'h0001;
        read_expect(periph_addr(mcu_pkg::reg_irq_flags), 16'h1 << mcu_pkg::irq_gpi0);
        check_value("irq", 16'h1 << mcu_pkg::irq_gpi0, {12'h000, irq});
        bus_write(periph_addr(mcu_pkg::reg_irq_flags), 16'h1 << mcu_pkg::irq_gpi0);
        read_expect(periph_addr(mcu_pkg::reg_irq_flags), '0);
        bus_write(periph_addr(mcu_pkg::reg_irq_enable), '0);
        @(posedge clk);
        @(negedge clk);
        check_value("irq", '0, {12'h000, irq});
    endtask

    task automatic uart_loopback();
        mcu_pkg::word_t b;
        mcu_pkg::word_t d;
        bus_write(periph_addr(mcu_pkg::reg_irq_flags), 16'h000F);
        for (int i = 0; i < 4; i++) begin
            wait_status(0, 1'b0);
            rng = xorshift32(rng);
            b = {8'h00, rng[7:0]};
            bus_write(periph_addr(mcu_pkg::reg_uart_data), b);
            wait_status(1, 1'b1);
            read_expect(periph_addr(mcu_pkg::reg_uart_data), b);
            bus_read(periph_addr(mcu_pkg::reg_uart_status), d);
            check_value("uart_status rx valid", '0, d & 16'h0002);
        end
        wait_status(0, 1'b0);
        read_expect(periph_addr(mcu_pkg::reg_irq_flags),
                    (16'h1 << mcu_pkg::irq_uart_tx) | (16'h1 << mcu_pkg::irq_uart_rx));
    endtask

    task automatic timer_wrap();
        mcu_pkg::word_t p;
        mcu_pkg::word_t d;
        rng = xorshift32(rng);
        p = 16'd5 + (rng[15:0] % 16'd36);
        bus_write(periph_addr(mcu_pkg::reg_irq_flags), 16'h000F);
        bus_write(periph_addr(mcu_pkg::reg_timer_period), p);
        // reads span more than a full period so the wrap is crossed
        for (int i = 0; i < p + 2; i++) begin
            bus_read(periph_addr(mcu_pkg::reg_timer_count), d);
            assert (d <= p) else begin
                $display("mismatch at %0t: timer_count expected at most %h got %h",
                         $time, p, d);
                mismatches++;
            end
        end
        repeat (2 * (p + 1)) @(posedge clk);
        bus_read(periph_addr(mcu_pkg::reg_irq_flags), d);
        check_value("irq_flags timer bit", 16'h1 << mcu_pkg::irq_timer,
                    d & (16'h1 << mcu_pkg::irq_timer));
        bus_write(periph_addr(mcu_pkg::reg_irq_enable), 16'h1 << mcu_pkg::irq_timer);
        @(posedge clk);
        @(negedge clk);
        check_value("irq timer bit", 16'h1, 16'(irq[mcu_pkg::irq_timer]));
        // period write restarts at 0 and a zero period holds it there
        bus_write(periph_addr(mcu_pkg::reg_timer_period), '0);
        read_expect(periph_addr(mcu_pkg::reg_timer_count), '0);
        read_expect(periph_addr(mcu_pkg::reg_timer_count), '0);
        bus_write(periph_addr(mcu_pkg::reg_irq_enable), '0);
        @(posedge clk);
        @(negedge clk);
        check_value("irq", '0, {12'h000, irq});
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        addr     = '0;
        wdata    = '0;
        write_en = 1'b0;
        gpi      = '0;
        rng      = 32'd10783;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        // gpo write while the internal reset is still high
        bus_write(periph_addr(mcu_pkg::reg_gpo), 16'hFFFF);
        // let the internal reset run out
        repeat (mcu_pkg::stretch_cycles) @(posedge clk);
        reset_values();
        memory_map();
        gpio_edge_irq();
        uart_loopback();
        timer_wrap();
        repeat (4) @(posedge clk);
        $display("mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 mismatches, other_errors, dut0.chk0.fail_count);
        if (mismatches + other_errors + dut0.chk0.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
design/mcu_pkg.sv
design/sys_bus_if.sv
design/reset_stretch.sv
design/word_ram.sv
design/bus_fabric.sv
design/interval_timer.sv
design/uart_core.sv
design/periph_block.sv
design/mcu_top.sv
tb/clock_gen.sv
tb/mcu_chk.sv
tb/mcu_tb.sv
